/* hw/ddr3_settings.svh */
// DDR3-800 sequencer constants
// Widths, timing in nCK and the shortened init waits in pclk ticks
`ifndef DDR3_SETTINGS_SVH
`define DDR3_SETTINGS_SVH

// Address split, {bank, row, column}
`define DDR3_ROW_W      13
`define DDR3_COL_W      10
`define DDR3_BANK_W     3
`define DDR3_ADDR_W     26
`define DDR3_DQ_W       16              // x16 part

// Quarter-rate slots and DQ beats per pclk
`define DDR3_SLOTS      4
`define DDR3_BEATS      8

// Timing in nCK at 2.5 ns
`define DDR3_RCD        6               // ACT to RD/WR
`define DDR3_CAS        6               // Read latency
`define DDR3_CWL        5               // Write latency
`define DDR3_RC         20              // ACT/REF to ACT/REF
`define DDR3_MRD        8               // MRS to MRS
`define DDR3_MOD        12              // MRS to other command
`define DDR3_SERDES     16              // Deserializer round trip

// Init waits, cut down for simulation
`define DDR3_RST_WAIT   1
`define DDR3_CKE_WAIT   19
`define DDR3_ZQ_WAIT    2
`define DDR3_CKE_AT     15              // Counter value where CKE goes high

`endif

/* hw/ddr3_pkg.sv */
// DDR3 sequencer types
// Command codes, FSM states and the mode-register word
`include "ddr3_settings.svh"

package ddr3_pkg;

    // {RAS#, CAS#, WE#}
    typedef enum logic [2:0] {
        CMD_MRS  = 3'b000,
        CMD_REF  = 3'b001,
        CMD_PRE  = 3'b010,
        CMD_ACT  = 3'b011,
        CMD_WR   = 3'b100,
        CMD_RD   = 3'b101,
        CMD_ZQCL = 3'b110,
        CMD_NOP  = 3'b111
    } cmd_t;

    typedef enum logic [3:0] {
        RST_WAIT, CKE_WAIT, CONFIG, ZQCL, IDLE, READ, WRITE, REFRESH
    } state_t;

    // MRS word, built as raw bits and sent as BA/A
    typedef union packed {
        logic [`DDR3_BANK_W+`DDR3_ROW_W-1:0] raw;
        struct packed {
            logic [`DDR3_BANK_W-1:0] bank;
            logic [`DDR3_ROW_W-1:0]  addr;
        } f;
    } mr_word_t;

    localparam logic [3:0] M_CAS     = 4'b0100;    // CL 6
    localparam logic [2:0] M_CWL     = 3'b000;     // CWL 5
    localparam logic [2:0] M_WR      = 3'b010;     // tWR 6
    localparam logic [1:0] M_BL      = 2'b01;      // BC4/BL8 on the fly
    localparam logic       M_DLL_RST = 1'b1;
    localparam logic [1:0] M_RTT_WR  = 2'b01;      // Dynamic ODT 60 ohm
    localparam logic [2:0] M_RTT_NOM = 3'b000;     // Single rank, off

    localparam logic [15:0] MR0 = {3'b000, 1'b0, M_WR, M_DLL_RST, 1'b0, M_CAS[3:1],
                                   1'b0, M_CAS[0], M_BL};
    localparam logic [15:0] MR1 = {3'b001, 3'b000, M_RTT_NOM[2], 2'b00, M_RTT_NOM[1],
                                   1'b0, 2'b00, M_RTT_NOM[0], 1'b0, 1'b0};
    localparam logic [15:0] MR2 = {3'b010, 2'b00, M_RTT_WR, 3'b000, M_CWL, 3'b000};
    localparam logic [15:0] MR3 = {3'b011, 13'b0};

endpackage

/* hw/ddr3_cmd_if.sv */
// Command request bus from the sequencer to the slot formatter
// One command per cycle, placed into its slot on the next edge
`include "ddr3_settings.svh"

interface ddr3_cmd_if;
    import ddr3_pkg::*;

    logic                         valid;
    cmd_t                         cmd;
    logic [$clog2(`DDR3_SLOTS)-1:0] slot;  // Quarter-cycle position
    logic [`DDR3_BANK_W-1:0]      bank;
    logic [`DDR3_ROW_W-1:0]       addr;   // Row, column or MRS payload
    logic                         ap;     // Forces A10
    logic                         bl8;    // Sets A12

    modport ctrl (
        output valid, cmd, slot, bank, addr, ap, bl8
    );

    modport slots (
        input valid, cmd, slot, bank, addr, ap, bl8
    );

endinterface

/* hw/ddr3_seq_ctrl.sv */
// DDR3 sequencer FSM
// Runs power-up, MRS and ZQCL, then serves read, write and refresh
// Commands are requested one cycle ahead of the slot outputs
`include "ddr3_settings.svh"

module ddr3_seq_ctrl (
    input  logic                    pclk,
    input  logic                    rst_lock_n,
    input  logic                    rd,
    input  logic                    wr,
    input  logic                    refresh,
    input  logic [`DDR3_ADDR_W-1:0] addr,
    ddr3_cmd_if.ctrl                cmd,
    output logic                    wr_beat0,
    output logic                    wr_beat1,
    output logic                    rd_issue,
    output logic                    rd_done,
    output logic                    busy,
    output logic                    data_ready,
    output logic                    ddr_reset_n,
    output logic                    ddr_cke
);
    import ddr3_pkg::*;

    // Config schedule, MRS spaced by tMRD, ZQCL after tMOD
    localparam logic [4:0] MR3_AT  = 5'(`DDR3_MRD / 4);
    localparam logic [4:0] MR1_AT  = 5'(`DDR3_MRD / 2);
    localparam logic [4:0] MR0_AT  = 5'(`DDR3_MRD * 3 / 4);
    localparam logic [4:0] ZQ_AT   = 5'(`DDR3_MRD * 3 / 4 + `DDR3_MOD / 4 + 2);
    // Operation schedule, cycle 1 is the first cycle after ACT request
    localparam logic [4:0] CS_AT   = 5'(`DDR3_RCD / 4);
    localparam int         CS_SLOT = `DDR3_RCD % 4;
    localparam logic [4:0] BEAT_AT = 5'((`DDR3_RCD + `DDR3_CWL) / 4);
    localparam logic [4:0] DONE_AT = 5'((`DDR3_RCD + `DDR3_CAS + `DDR3_SERDES) / 4 + 1);
    localparam logic [4:0] WR_END  = BEAT_AT + 5'd3;   // Beats plus write recovery
    localparam logic [4:0] REF_END = 5'(`DDR3_RC / 4);

    state_t                  state;
    logic [4:0]              cycle;       // Step within a schedule, saturates
    logic                    tick;        // Pulse when tick_cnt runs out
    logic [4:0]              tick_cnt;
    logic [`DDR3_BANK_W-1:0] bank;
    logic [`DDR3_ROW_W-1:0]  row;
    logic [`DDR3_COL_W-1:0]  col;
    mr_word_t                mr_word;

    assign {bank, row, col} = addr;

    always_ff @(posedge pclk) begin
        if (!rst_lock_n) begin
            state       <= RST_WAIT;
            cycle       <= '0;
            tick        <= 1'b0;
            tick_cnt    <= 5'(`DDR3_RST_WAIT);
            busy        <= 1'b1;
            data_ready  <= 1'b0;
            ddr_reset_n <= 1'b0;
            ddr_cke     <= 1'b0;
        end else begin
            cycle    <= (cycle == 5'd31) ? cycle : cycle + 5'd1;
            tick     <= (tick_cnt == 5'd1);
            tick_cnt <= (tick_cnt == '0) ? '0 : tick_cnt - 5'd1;
            case (state)
                RST_WAIT: if (tick) begin
                    ddr_reset_n <= 1'b1;                 // Release RESET#
                    tick_cnt    <= 5'(`DDR3_CKE_WAIT);
                    state       <= CKE_WAIT;
                end
                CKE_WAIT: begin
                    if (tick_cnt == 5'(`DDR3_CKE_AT))
                        ddr_cke <= 1'b1;                 // Leaves tXPR before first MRS
                    if (tick) begin
                        state <= CONFIG;
                        cycle <= '0;
                    end
                end
                CONFIG: if (cycle == ZQ_AT) begin
                    tick_cnt <= 5'(`DDR3_ZQ_WAIT);       // tZQinit
                    state    <= ZQCL;
                end
                ZQCL: if (tick) begin
                    busy  <= 1'b0;
                    state <= IDLE;
                end
                IDLE: if (rd || wr || refresh) begin
                    // rd wins over wr, wr over refresh
                    state <= rd ? READ : (wr ? WRITE : REFRESH);
                    cycle <= 5'd1;
                    busy  <= 1'b1;
                end
                READ: begin
                    if (cycle == DONE_AT)
                        data_ready <= 1'b1;
                    if (cycle == DONE_AT + 5'd1) begin
                        data_ready <= 1'b0;
                        busy       <= 1'b0;
                        state      <= IDLE;
                    end
                end
                WRITE: if (cycle == WR_END) begin
                    busy  <= 1'b0;
                    state <= IDLE;
                end
                REFRESH: if (cycle == REF_END) begin    // tRC
                    busy  <= 1'b0;
                    state <= IDLE;
                end
                default: state <= RST_WAIT;
            endcase
        end
    end

    // Command request for the next cycle's slots
    always_comb begin
        cmd.valid   = 1'b0;
        cmd.cmd     = CMD_NOP;
        cmd.slot    = '0;
        cmd.bank    = '0;
        cmd.addr    = '0;
        cmd.ap      = 1'b0;
        cmd.bl8     = 1'b0;
        mr_word.raw = '0;
        case (state)
            CONFIG: begin
                cmd.valid = 1'b1;
                cmd.cmd   = CMD_MRS;
                case (cycle)
                    5'd0:    mr_word.raw = MR2;
                    MR3_AT:  mr_word.raw = MR3;
                    MR1_AT:  mr_word.raw = MR1;
                    MR0_AT:  mr_word.raw = MR0;
                    ZQ_AT: begin
                        cmd.cmd = CMD_ZQCL;
                        cmd.ap  = 1'b1;                  // A10 high, long calibration
                    end
                    default: cmd.valid = 1'b0;
                endcase
                cmd.bank = mr_word.f.bank;
                cmd.addr = mr_word.f.addr;
            end
            IDLE: begin
                cmd.valid = rd || wr || refresh;
                cmd.cmd   = (rd || wr) ? CMD_ACT : CMD_REF;  // REF needs no address
                if (rd || wr) begin
                    cmd.bank = bank;
                    cmd.addr = row;
                end
            end
            READ, WRITE: if (cycle == CS_AT) begin
                cmd.valid = 1'b1;
                cmd.cmd   = (state == READ) ? CMD_RD : CMD_WR;
                cmd.slot  = CS_SLOT[1:0];                // RCD lands mid-cycle
                cmd.bank  = bank;
                cmd.addr[`DDR3_COL_W-1:0] = col;
                cmd.ap    = 1'b1;                        // Auto precharge, no PRE needed
                cmd.bl8   = (state == READ);             // BL8 read, BC4 write
            end
            default: ;
        endcase
    end

    // Strobes for the data lanes
    assign wr_beat0 = (state == WRITE) && (cycle == BEAT_AT);
    assign wr_beat1 = (state == WRITE) && (cycle == BEAT_AT + 5'd1);
    assign rd_issue = (state == IDLE) && rd;
    assign rd_done  = (state == READ) && (cycle == DONE_AT);   // Loads the data_ready cycle

endmodule

/* hw/ddr3_cmd_slots.sv */
// Quarter-rate command slot register
// Four RAS#/CAS#/WE#, A and BA slots per pclk, NOP unless requested
`include "ddr3_settings.svh"

module ddr3_cmd_slots (
    input  logic                                pclk,
    input  logic                                rst_lock_n,
    ddr3_cmd_if.slots                           cmd,
    output logic [`DDR3_SLOTS-1:0]              ddr_ras_n,
    output logic [`DDR3_SLOTS-1:0]              ddr_cas_n,
    output logic [`DDR3_SLOTS-1:0]              ddr_we_n,
    output logic [`DDR3_SLOTS*`DDR3_ROW_W-1:0]  ddr_a,
    output logic [`DDR3_SLOTS*`DDR3_BANK_W-1:0] ddr_ba
);
    import ddr3_pkg::*;

    logic [`DDR3_ROW_W-1:0] a_word;

    // A10 is auto precharge, A12 is BL8 on the fly
    always_comb begin
        a_word     = cmd.addr;
        a_word[10] = cmd.addr[10] | cmd.ap;
        a_word[12] = cmd.addr[12] | cmd.bl8;
    end

    always_ff @(posedge pclk) begin
        for (int i = 0; i < `DDR3_SLOTS; i++) begin
            {ddr_ras_n[i], ddr_cas_n[i], ddr_we_n[i]} <= CMD_NOP;
        end
        ddr_a  <= '0;
        ddr_ba <= '0;
        if (rst_lock_n && cmd.valid) begin
            {ddr_ras_n[cmd.slot], ddr_cas_n[cmd.slot], ddr_we_n[cmd.slot]} <= cmd.cmd;
            ddr_a[cmd.slot*`DDR3_ROW_W +: `DDR3_ROW_W]   <= a_word;
            ddr_ba[cmd.slot*`DDR3_BANK_W +: `DDR3_BANK_W] <= cmd.bank;
        end
    end

endmodule

/* hw/ddr3_write_lane.sv */
// BC4 write lane formatter
// Builds DQ, DQS, DM and output enables over two pclk cycles
// Beat 0 sits in the top bits of each vector
`include "ddr3_settings.svh"

module ddr3_write_lane (
    input  logic                                 pclk,
    input  logic                                 rst_lock_n,
    input  logic                                 wr_beat0,
    input  logic                                 wr_beat1,
    input  logic [`DDR3_DQ_W-1:0]                din,
    input  logic [1:0]                           word_sel,
    output logic [`DDR3_BEATS*`DDR3_DQ_W-1:0]    dq_out,
    output logic [`DDR3_BEATS/2-1:0]             dq_oen,
    output logic [`DDR3_BEATS-1:0]               dqs_out,
    output logic [`DDR3_BEATS/2-1:0]             dqs_oen,
    output logic [`DDR3_BEATS-1:0]               dm_out
);

    // Strobes, enables and mask
    always_ff @(posedge pclk) begin
        if (!rst_lock_n) begin
            dqs_out <= '0;
            dqs_oen <= '1;                     // All pads off
            dq_oen  <= '1;
            dm_out  <= '1;
        end else begin
            dqs_out <= '0;
            dqs_oen <= '1;
            dq_oen  <= '1;
            dm_out  <= '1;
            if (wr_beat0) begin
                dqs_out   <= 8'b1111_1110;     // Preamble low on beat 7
                dqs_oen   <= 4'b1110;          // Last beat pair on
                dq_oen    <= 4'b1110;
                dm_out[0] <= (word_sel != 2'd0);
            end else if (wr_beat1) begin
                dqs_out   <= 8'b1010_0000;     // Two strobe toggles then idle
                dqs_oen   <= 4'b0011;
                dq_oen    <= 4'b0011;
                dm_out[7] <= (word_sel != 2'd1);
                dm_out[6] <= (word_sel != 2'd2);
                dm_out[5] <= (word_sel != 2'd3);
            end
        end
    end

    // Data beats, din copied to each of the four BC4 words
    always_ff @(posedge pclk) begin
        dq_out <= '0;
        if (wr_beat0)
            dq_out[`DDR3_DQ_W-1:0] <= din;                      // Beat 7
        else if (wr_beat1)
            dq_out[`DDR3_BEATS*`DDR3_DQ_W-1 -: 3*`DDR3_DQ_W] <= {3{din}};  // Beats 0 to 2
    end

endmodule

/* hw/ddr3_read_capture.sv */
// Read burst capture
// Latches the column word index at issue, loads the burst with data_ready
`include "ddr3_settings.svh"

module ddr3_read_capture (
    input  logic                              pclk,
    input  logic                              rst_lock_n,
    input  logic                              rd_issue,
    input  logic                              rd_done,
    input  logic [2:0]                        word_sel,
    input  logic [`DDR3_BEATS*`DDR3_DQ_W-1:0] dq_beats,
    output logic [`DDR3_DQ_W-1:0]             dout,
    output logic [`DDR3_BEATS*`DDR3_DQ_W-1:0] dout128
);

    logic [2:0] sel_q;        // Word within the BL8 burst
    logic [6:0] base;         // Bit offset of the selected beat

    // Beat 0 in the top bits, so beat n starts at (7-n)*16
    assign base = {~sel_q, 4'b0000};

    always_ff @(posedge pclk) begin
        if (!rst_lock_n) begin
            sel_q   <= '0;
            dout    <= '0;
            dout128 <= '0;
        end else begin
            if (rd_issue)
                sel_q <= word_sel;
            if (rd_done) begin                   // Valid with data_ready
                dout128 <= dq_beats;
                dout    <= dq_beats[base +: `DDR3_DQ_W];
            end
        end
    end

endmodule

/* hw/ddr3_phy_top.sv */
// DDR3-800 quarter-rate PHY controller top
// Sequencer, slot formatter and data lanes with parallel beat vectors
`include "ddr3_settings.svh"

module ddr3_phy_top (
    input  logic                                 pclk,
    input  logic                                 rst_lock_n,
    input  logic                                 rd,
    input  logic                                 wr,
    input  logic                                 refresh,
    input  logic [`DDR3_ADDR_W-1:0]              addr,
    input  logic [`DDR3_DQ_W-1:0]                din,
    input  logic [`DDR3_BEATS*`DDR3_DQ_W-1:0]    dq_beats,    // Deserialized read burst
    output logic                                 busy,
    output logic                                 data_ready,
    output logic [`DDR3_DQ_W-1:0]                dout,
    output logic [`DDR3_BEATS*`DDR3_DQ_W-1:0]    dout128,
    output logic                                 ddr_reset_n,
    output logic                                 ddr_cke,
    output logic [`DDR3_SLOTS-1:0]               ddr_ras_n,
    output logic [`DDR3_SLOTS-1:0]               ddr_cas_n,
    output logic [`DDR3_SLOTS-1:0]               ddr_we_n,
    output logic [`DDR3_SLOTS*`DDR3_ROW_W-1:0]   ddr_a,
    output logic [`DDR3_SLOTS*`DDR3_BANK_W-1:0]  ddr_ba,
    output logic [`DDR3_BEATS*`DDR3_DQ_W-1:0]    dq_out,
    output logic [`DDR3_BEATS/2-1:0]             dq_oen,
    output logic [`DDR3_BEATS-1:0]               dqs_out,
    output logic [`DDR3_BEATS/2-1:0]             dqs_oen,
    output logic [`DDR3_BEATS-1:0]               dm_out
);

    logic wr_beat0;
    logic wr_beat1;
    logic rd_issue;
    logic rd_done;

    ddr3_cmd_if cmd_bus ();

    ddr3_seq_ctrl u_seq_ctrl (
        .pclk        (pclk),
        .rst_lock_n  (rst_lock_n),
        .rd          (rd),
        .wr          (wr),
        .refresh     (refresh),
        .addr        (addr),
        .cmd         (cmd_bus.ctrl),
        .wr_beat0    (wr_beat0),
        .wr_beat1    (wr_beat1),
        .rd_issue    (rd_issue),
        .rd_done     (rd_done),
        .busy        (busy),
        .data_ready  (data_ready),
        .ddr_reset_n (ddr_reset_n),
        .ddr_cke     (ddr_cke)
    );

    ddr3_cmd_slots u_cmd_slots (
        .pclk       (pclk),
        .rst_lock_n (rst_lock_n),
        .cmd        (cmd_bus.slots),
        .ddr_ras_n  (ddr_ras_n),
        .ddr_cas_n  (ddr_cas_n),
        .ddr_we_n   (ddr_we_n),
        .ddr_a      (ddr_a),
        .ddr_ba     (ddr_ba)
    );

    // BC4 word mask from the low column bits
    ddr3_write_lane u_write_lane (
        .pclk       (pclk),
        .rst_lock_n (rst_lock_n),
        .wr_beat0   (wr_beat0),
        .wr_beat1   (wr_beat1),
        .din        (din),
        .word_sel   (addr[1:0]),
        .dq_out     (dq_out),
        .dq_oen     (dq_oen),
        .dqs_out    (dqs_out),
        .dqs_oen    (dqs_oen),
        .dm_out     (dm_out)
    );

    ddr3_read_capture u_read_capture (
        .pclk       (pclk),
        .rst_lock_n (rst_lock_n),
        .rd_issue   (rd_issue),
        .rd_done    (rd_done),
        .word_sel   (addr[2:0]),      // Word within the BL8 burst
        .dq_beats   (dq_beats),
        .dout       (dout),
        .dout128    (dout128)
    );

endmodule

/* sim/ddr3_phy_chk.sv */
// Protocol checks on the DDR3 sequencer top
// Slot exclusivity, busy cover and the data_ready pulse width

module ddr3_phy_chk (
    input logic       pclk,
    input logic       rst_lock_n,
    input logic       busy,
    input logic       data_ready,
    input logic [3:0] ddr_ras_n,
    input logic [3:0] ddr_cas_n,
    input logic [3:0] ddr_we_n
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [3:0] active;                                // Slot carries a non-NOP code

    assign active = ~(ddr_ras_n & ddr_cas_n & ddr_we_n);

    // Every command belongs to an init step or an accepted operation
    a_cmd_busy: assert property (@(posedge pclk) disable iff (!rst_lock_n)
        (|active) |-> busy)
        else $error("command issued while busy is low");

    a_ready_pulse: assert property (@(posedge pclk) disable iff (!rst_lock_n)
        data_ready |=> !data_ready)
        else $error("data_ready held longer than one cycle");

    a_one_slot: assert property (@(posedge pclk) disable iff (!rst_lock_n)
        $onehot0(active))
        else $error("more than one slot active in a cycle");

endmodule

bind ddr3_phy_top ddr3_phy_chk u_phy_chk (
    .pclk       (pclk),
    .rst_lock_n (rst_lock_n),
    .busy       (busy),
    .data_ready (data_ready),
    .ddr_ras_n  (ddr_ras_n),
    .ddr_cas_n  (ddr_cas_n),
    .ddr_we_n   (ddr_we_n)
);

/* sim/ddr3_phy_tb.sv */
// Testbench for the DDR3 sequencer top
// Directed init, write, read, refresh and priority tests, then LFSR pairs

module ddr3_phy_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ddr3_pkg::*;

    logic         pclk;
    logic         rst_lock_n;
    logic         rd;
    logic         wr;
    logic         refresh;
    logic [25:0]  addr;
    logic [15:0]  din;
    logic [127:0] dq_beats;                      // Memory model burst
    logic         busy;
    logic         data_ready;
    logic         ddr_reset_n;
    logic         ddr_cke;
    logic [15:0]  dout;
    logic [127:0] dout128;
    logic [127:0] dq_out;
    logic [3:0]   ddr_ras_n;
    logic [3:0]   ddr_cas_n;
    logic [3:0]   ddr_we_n;
    logic [3:0]   dq_oen;
    logic [3:0]   dqs_oen;
    logic [51:0]  ddr_a;
    logic [11:0]  ddr_ba;
    logic [7:0]   dqs_out;
    logic [7:0]   dm_out;

    int          errors;
    int          test_errors;
    int          tests_run;
    string       cur_test;
    logic [15:0] lfsr;
    logic [15:0] mem [int unsigned];             // Written words by address

    ddr3_phy_top u_ddr3_phy_top (.*);

    always #2 pclk = ~pclk;                      // 4 ns period

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Unwritten words return a pattern of the full address
    function automatic logic [15:0] read_word(input logic [25:0] a);
        if (mem.exists(32'(a)))
            return mem[32'(a)];
        return a[15:0] ^ {a[25:16], 6'h2b};
    endfunction

    function automatic logic [127:0] burst_of(input logic [25:0] a);
        logic [127:0] b;
        for (int n = 0; n < 8; n++)
            b[(7-n)*16 +: 16] = read_word({a[25:3], 3'(n)});   // Beat 0 on top
        return b;
    endfunction

    task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("mismatch %s %s expected %h actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("test %s: %s", cur_test, (test_errors == 0) ? "ok" : "errors");
        errors += test_errors;
        tests_run++;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < 50) begin
            @(negedge pclk);
            n++;
        end
        if (busy) begin
            $display("%s: timeout waiting for busy to fall", cur_test);
            test_errors++;
        end
    endtask

    // Expected slot contents k cycles after the request
    // Kind is 0 for read, 1 for write and 2 for refresh
    task automatic check_slots(input int k, input int kind, input logic [25:0] a);
        logic [2:0]  exp_c;
        logic [2:0]  exp_ba;
        logic [12:0] exp_a;
        logic        chk_addr;
        for (int i = 0; i < 4; i++) begin
            exp_c    = CMD_NOP;
            exp_ba   = '0;
            exp_a    = '0;
            chk_addr = 1'b1;
            if (k == 1 && i == 0) begin
                if (kind == 2) begin
                    exp_c    = CMD_REF;
                    chk_addr = 1'b0;               // Address is don't care
                end else begin
                    exp_c  = CMD_ACT;
                    exp_ba = a[25:23];
                    exp_a  = a[22:10];              // Row
                end
            end
            if (k == 2 && i == 2 && kind != 2) begin
                exp_c  = (kind == 0) ? CMD_RD : CMD_WR;
                exp_ba = a[25:23];
                exp_a  = {kind == 0, 1'b0, 1'b1, a[9:0]};  // A12 only on reads and A10 always
            end
            check($sformatf("slot%0d cmd k%0d", i, k), 128'(exp_c),
                  128'({ddr_ras_n[i], ddr_cas_n[i], ddr_we_n[i]}));
            if (chk_addr) begin
                check($sformatf("slot%0d ba k%0d", i, k), 128'(exp_ba), 128'(ddr_ba[i*3 +: 3]));
                check($sformatf("slot%0d a k%0d", i, k), 128'(exp_a), 128'(ddr_a[i*13 +: 13]));
            end
        end
    endtask

    // BC4 lane patterns for the two beat cycles
    // Phase 0 carries the first data word in beat 7, phase 1 the rest in beats 0 to 2
    task automatic check_beats(input int phase, input logic [1:0] ws, input logic [15:0] d);
        if (phase == 0) begin
            check("dqs0", 128'(8'hFE), 128'(dqs_out));
            check("dqs_oen0", 128'(4'b1110), 128'(dqs_oen));
            check("dq_oen0", 128'(4'b1110), 128'(dq_oen));
            check("dm0", 128'({7'h7f, ws != 2'd0}), 128'(dm_out));
            check("dq0", 128'(d), dq_out);
        end else begin
            check("dqs1", 128'(8'hA0), 128'(dqs_out));
            check("dqs_oen1", 128'(4'b0011), 128'(dqs_oen));
            check("dq_oen1", 128'(4'b0011), 128'(dq_oen));
            check("dm1", 128'({ws != 2'd1, ws != 2'd2, ws != 2'd3, 5'h1f}), 128'(dm_out));
            check("dq1", {d, d, d, 80'b0}, dq_out);
        end
    endtask

    // One request followed by per-cycle checks until busy falls
    task automatic run_op(input logic do_rd, input logic do_wr, input logic do_ref,
                          input logic [25:0] a, input logic [15:0] d, input logic poke);
        int           k;
        int           kind;
        int           busy_end;
        logic [127:0] exp_burst;
        logic [15:0]  exp_word;
        kind      = do_rd ? 0 : (do_wr ? 1 : 2);
        busy_end  = (kind == 0) ? 10 : 6;
        exp_burst = burst_of(a);
        exp_word  = read_word(a);
        wait_idle();
        @(posedge pclk);
        rd       <= do_rd;
        wr       <= do_wr;
        refresh  <= do_ref;
        addr     <= a;
        din      <= d;
        dq_beats <= ~exp_burst;                    // Stale bus until the burst arrives
        @(posedge pclk);                           // Request sampled here
        rd       <= 1'b0;
        wr       <= poke;                          // Extra requests while busy
        refresh  <= poke;
        k = 0;
        do begin
            @(negedge pclk);
            k++;
            check_slots(k, kind, a);
            check($sformatf("data_ready k%0d", k), 128'(kind == 0 && k == 9), 128'(data_ready));
            if (kind == 0 && k == 9) begin
                check("dout", 128'(exp_word), 128'(dout));
                check("dout128", exp_burst, dout128);
            end
            if (kind == 1 && (k == 3 || k == 4))
                check_beats(k - 3, a[1:0], d);
            if (poke && k == 4) begin
                @(posedge pclk);
                wr      <= 1'b0;
                refresh <= 1'b0;
            end
            if (kind == 0 && k == 7) begin
                @(posedge pclk);
                dq_beats <= exp_burst;             // Deserializer output for the capture edge
            end
            if (kind == 0 && k == 8) begin
                @(posedge pclk);
                dq_beats <= ~exp_burst;
            end
        end while (busy && k < 30);
        if (busy) begin
            $display("%s: timeout waiting for the operation to finish", cur_test);
            test_errors++;
        end else begin
            check("busy fall", 128'(busy_end), 128'(k));
        end
        if (kind == 1)
            mem[32'(a)] = d;
    endtask

    task automatic test_init();
        int          cyc;
        int          rst_at;
        int          cke_at;
        logic [2:0]  c;
        logic [2:0]  q_cmd[$];
        logic [15:0] q_word[$];
        int          q_cyc[$];
        int          q_slot[$];
        logic [15:0] mr_exp[4];
        start_test("init");
        mr_exp = '{MR2, MR3, MR1, MR0};
        rst_at = -1;
        cke_at = -1;
        cyc    = 0;
        while (busy && cyc < 200) begin
            @(negedge pclk);
            cyc++;
            if (ddr_reset_n && rst_at < 0)
                rst_at = cyc;
            if (ddr_cke && cke_at < 0)
                cke_at = cyc;
            for (int i = 0; i < 4; i++) begin
                c = {ddr_ras_n[i], ddr_cas_n[i], ddr_we_n[i]};
                if (c != CMD_NOP) begin
                    q_cmd.push_back(c);
                    q_word.push_back({ddr_ba[i*3 +: 3], ddr_a[i*13 +: 13]});
                    q_cyc.push_back(cyc);
                    q_slot.push_back(i);
                end
            end
        end
        if (busy) begin
            $display("init: timeout waiting for the init sequence to finish");
            test_errors++;
        end
        if (rst_at < 0 || cke_at <= rst_at) begin
            $display("init: ddr_reset_n did not rise before ddr_cke");
            test_errors++;
        end
        check("command count", 128'(5), 128'(q_cmd.size()));
        if (q_cmd.size() == 5) begin
            for (int j = 0; j < 4; j++) begin
                check($sformatf("mrs%0d cmd", j), 128'(CMD_MRS), 128'(q_cmd[j]));
                check($sformatf("mrs%0d word", j), 128'(mr_exp[j]), 128'(q_word[j]));
                check($sformatf("mrs%0d slot", j), 128'(0), 128'(q_slot[j]));
                if (j > 0)
                    check($sformatf("mrs%0d gap", j), 128'(2), 128'(q_cyc[j] - q_cyc[j-1]));
            end
            check("zqcl cmd", 128'(CMD_ZQCL), 128'(q_cmd[4]));
            check("zqcl a10", 128'(1), 128'(q_word[4][10]));
            check("zqcl gap", 128'(5), 128'(q_cyc[4] - q_cyc[3]));
        end
        end_test();
    endtask

    initial begin
        logic [25:0] a;
        logic [15:0] d;
        pclk       = 1'b0;
        rst_lock_n = 1'b0;
        rd         = 1'b0;
        wr         = 1'b0;
        refresh    = 1'b0;
        addr       = '0;
        din        = '0;
        dq_beats   = '0;
        lfsr       = 16'd31710;
        errors     = 0;
        tests_run  = 0;

        start_test("reset");
        repeat (3) @(posedge pclk);
        @(negedge pclk);
        check("busy", 128'(1), 128'(busy));
        check("ready/cke/reset_n", 128'(0), 128'({data_ready, ddr_cke, ddr_reset_n}));
        check("slots", 128'(12'hfff), 128'({ddr_ras_n, ddr_cas_n, ddr_we_n}));
        check("oen", 128'(8'hff), 128'({dq_oen, dqs_oen}));
        check("dm", 128'(8'hff), 128'(dm_out));
        end_test();
        @(posedge pclk);
        rst_lock_n <= 1'b1;                      // Fourth edge with reset low
        @(posedge pclk);

        test_init();

        a = 26'(rand_bits(26));
        d = 16'(rand_bits(16));
        start_test("write");
        run_op(1'b0, 1'b1, 1'b0, a, d, 1'b0);
        end_test();
        start_test("read");
        run_op(1'b1, 1'b0, 1'b0, a, 16'h0, 1'b0);
        end_test();
        start_test("refresh");
        run_op(1'b0, 1'b0, 1'b1, '0, 16'h0, 1'b0);
        end_test();
        start_test("priority");
        run_op(1'b1, 1'b1, 1'b1, 26'(rand_bits(26)), 16'(rand_bits(16)), 1'b1);
        run_op(1'b0, 1'b1, 1'b1, 26'(rand_bits(26)), 16'(rand_bits(16)), 1'b1);
        end_test();

        start_test("random");
        for (int p = 0; p < 6; p++) begin
            a = 26'(rand_bits(26));
            d = 16'(rand_bits(16));
            run_op(1'b0, 1'b1, 1'b0, a, d, 1'b0);
            run_op(1'b1, 1'b0, 1'b0, a, 16'h0, 1'b0);
            check($sformatf("readback %0d", p), 128'(d), 128'(dout));
        end
        end_test();

        $display("tests %0d errors %0d", tests_run, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* compile.f */
+incdir+hw
hw/ddr3_pkg.sv
hw/ddr3_cmd_if.sv
hw/ddr3_seq_ctrl.sv
hw/ddr3_cmd_slots.sv
hw/ddr3_write_lane.sv
hw/ddr3_read_capture.sv
hw/ddr3_phy_top.sv
sim/ddr3_phy_chk.sv
sim/ddr3_phy_tb.sv

/* Makefile */
# Verilator build and run for the DDR3 sequencer testbench

VERILATOR ?= verilator
TOP       ?= ddr3_phy_tb
OBJ_DIR   ?= obj_dir
FLIST     ?= compile.f
VFLAGS    ?= --binary --assert -j 0

SRCS := $(wildcard hw/*.sv hw/*.svh sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
